// File: rtl/cu_ctrl_defines.svh
/*
 * Vertex CU control widths and counts
 * Shared sizing for the response routing and done counters
 */
`ifndef CU_CTRL_DEFINES_SVH
`define CU_CTRL_DEFINES_SVH

// Compute unit population
`define NUM_CU            4
`define CU_ID_BITS        2

// Configuration word, active-CU count in the low half
`define CONFIG_BITS       64
`define CONFIG_COUNT_BITS 32

// Response fields
`define ARRAY_CLASS_BITS  4
`define TAG_BITS          8
`define DATA_BITS         64

// Progress counters and totals
`define VERTEX_COUNT_BITS 32
`define EDGE_COUNT_BITS   32

`endif

// File: rtl/cu_ctrl_pkg.sv
/*
 * Vertex CU control types
 * Array-class tags carried on memory responses and the CU index type
 */
`default_nettype none
`include "cu_ctrl_defines.svh"

package cu_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// Graph array that a memory response belongs to
	////////////////////////////////////////////////////////////

	// Zero encodes an invalid slot
	typedef enum logic [`ARRAY_CLASS_BITS-1:0] {
		STRUCT_INVALID        = 4'd0,
		EDGE_ARRAY_SRC        = 4'd1,
		EDGE_ARRAY_DEST       = 4'd2,
		EDGE_ARRAY_WEIGHT     = 4'd3,
		INV_EDGE_ARRAY_SRC    = 4'd4,
		INV_EDGE_ARRAY_DEST   = 4'd5,
		INV_EDGE_ARRAY_WEIGHT = 4'd6,
		READ_GRAPH_DATA       = 4'd7,
		VERTEX_ARRAY          = 4'd8
	} array_class_t;

	////////////////////////////////////////////////////////////
	// Compute unit index
	////////////////////////////////////////////////////////////

	typedef logic [`CU_ID_BITS-1:0] cu_id_t;

endpackage

`default_nettype wire

// File: rtl/cu_enable_config.sv
/*
 * CU enable configuration
 * Registers the global enable and the active-CU count,
 * then expands the count into a per-CU enable mask
 */
`timescale 1ns/1ps
`default_nettype none
`include "cu_ctrl_defines.svh"

module cu_enable_config (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled_in,
	input  logic [`CONFIG_BITS-1:0] cu_configure,
	output logic                    enabled,
	output logic [`NUM_CU-1:0]      enable_cu
);

	logic [`CONFIG_COUNT_BITS-1:0] active_count;
	logic [`NUM_CU-1:0]            mask_next;

	// Global enable, one cycle behind the input
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	// Only a nonzero word replaces the stored count
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active_count <= '0;
		end else if (enabled && (|cu_configure)) begin
			active_count <= cu_configure[`CONFIG_COUNT_BITS-1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Count to mask
	////////////////////////////////////////////////////////////

	// Counts above NUM_CU simply set every bit
	always_comb begin
		for (int i = 0; i < `NUM_CU; i++) begin
			mask_next[i] = (active_count > `CONFIG_COUNT_BITS'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_cu <= '0;
		end else if (enabled) begin
			enable_cu <= mask_next;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cu_response_classify.sv
/*
 * Response classify stage
 * Captures one tagged memory response per cycle and keeps only
 * the six edge-array classes, everything else becomes an empty slot
 */
`timescale 1ns/1ps
`default_nettype none
`include "cu_ctrl_defines.svh"

module cu_response_classify
	import cu_ctrl_pkg::*;
#(
	parameter int PAYLOAD_BITS = `TAG_BITS
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  logic                    in_valid,
	input  cu_id_t                  in_cu_id,
	input  array_class_t            in_class,
	input  logic [PAYLOAD_BITS-1:0] in_payload,
	output logic                    out_valid,
	output cu_id_t                  out_cu_id,
	output logic [PAYLOAD_BITS-1:0] out_payload
);

	logic is_edge_class;
	logic forward;

	////////////////////////////////////////////////////////////
	// Class decode
	////////////////////////////////////////////////////////////

	// Graph data, vertex array and invalid tags are dropped here
	always_comb begin
		case (in_class)
			EDGE_ARRAY_SRC,
			EDGE_ARRAY_DEST,
			EDGE_ARRAY_WEIGHT,
			INV_EDGE_ARRAY_SRC,
			INV_EDGE_ARRAY_DEST,
			INV_EDGE_ARRAY_WEIGHT: begin
				is_edge_class = 1'b1;
			end
			default: begin
				is_edge_class = 1'b0;
			end
		endcase
	end

	assign forward = enabled && in_valid && is_edge_class;

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= forward;
		end
	end

	// Empty slots carry a cleared payload and CU id
	always_ff @(posedge clock) begin
		if (forward) begin
			out_cu_id   <= in_cu_id;
			out_payload <= in_payload;
		end else begin
			out_cu_id   <= '0;
			out_payload <= '0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cu_response_route.sv
/*
 * Response route stage
 * Decodes the CU id of a response against the enable mask and
 * delivers it on that CU's lane two cycles after capture
 */
`timescale 1ns/1ps
`default_nettype none
`include "cu_ctrl_defines.svh"

module cu_response_route
	import cu_ctrl_pkg::*;
#(
	parameter int PAYLOAD_BITS = `TAG_BITS
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  logic [`NUM_CU-1:0]      enable_cu,
	input  logic                    in_valid,
	input  cu_id_t                  in_cu_id,
	input  logic [PAYLOAD_BITS-1:0] in_payload,
	output logic [`NUM_CU-1:0]      cu_valid,
	output logic [PAYLOAD_BITS-1:0] cu_payload [0:`NUM_CU-1]
);

	logic [`NUM_CU-1:0]      select_next;
	logic [`NUM_CU-1:0]      select;
	logic [PAYLOAD_BITS-1:0] held_payload;

	////////////////////////////////////////////////////////////
	// Capture and decode
	////////////////////////////////////////////////////////////

	// Mask sampled here is the one that decides delivery
	always_comb begin
		for (int i = 0; i < `NUM_CU; i++) begin
			select_next[i] = enabled && in_valid && enable_cu[i]
				&& (in_cu_id == cu_id_t'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			select <= '0;
		end else begin
			select <= select_next;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled && in_valid) begin
			held_payload <= in_payload;
		end
	end

	////////////////////////////////////////////////////////////
	// Per-CU output lanes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_valid <= '0;
		end else begin
			cu_valid <= select;
		end
	end

	// Unselected lanes read as zero
	always_ff @(posedge clock) begin
		for (int i = 0; i < `NUM_CU; i++) begin
			cu_payload[i] <= select[i] ? held_payload : '0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cu_done_counter.sv
/*
 * Done counters
 * Sums the per-CU vertex and edge progress counters into two totals
 */
`timescale 1ns/1ps
`default_nettype none
`include "cu_ctrl_defines.svh"

module cu_done_counter (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled,
	input  logic [`VERTEX_COUNT_BITS-1:0] vertex_count_cu [0:`NUM_CU-1],
	input  logic [`EDGE_COUNT_BITS-1:0]   edge_count_cu   [0:`NUM_CU-1],
	output logic [`VERTEX_COUNT_BITS-1:0] vertex_done_total,
	output logic [`EDGE_COUNT_BITS-1:0]   edge_done_total
);

	logic [`VERTEX_COUNT_BITS-1:0] vertex_count_q [0:`NUM_CU-1];
	logic [`EDGE_COUNT_BITS-1:0]   edge_count_q   [0:`NUM_CU-1];
	logic [`VERTEX_COUNT_BITS-1:0] vertex_sum;
	logic [`EDGE_COUNT_BITS-1:0]   edge_sum;

	// Counter inputs come from the CUs, register them first
	always_ff @(posedge clock) begin
		vertex_count_q <= vertex_count_cu;
		edge_count_q   <= edge_count_cu;
	end

	// Sums wrap at the total width
	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			vertex_sum = vertex_sum + vertex_count_q[i];
			edge_sum   = edge_sum + edge_count_q[i];
		end
	end

	// Totals hold while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_total <= '0;
			edge_done_total   <= '0;
		end else if (enabled) begin
			vertex_done_total <= vertex_sum;
			edge_done_total   <= edge_sum;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cu_vertex_control_top.sv
/*
 * Vertex CU control, response side
 * Configuration, classify and route pipelines for read responses,
 * write responses and read data, plus the done totals
 */
`timescale 1ns/1ps
`default_nettype none
`include "cu_ctrl_defines.svh"

module cu_vertex_control_top
	import cu_ctrl_pkg::*;
(
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled_in,
	input  logic [`CONFIG_BITS-1:0]       cu_configure,
	input  logic                          read_response_valid,
	input  cu_id_t                        read_response_cu_id,
	input  array_class_t                  read_response_class,
	input  logic [`TAG_BITS-1:0]          read_response_tag,
	input  logic                          write_response_valid,
	input  cu_id_t                        write_response_cu_id,
	input  logic [`TAG_BITS-1:0]          write_response_tag,
	input  logic                          read_data_valid,
	input  cu_id_t                        read_data_cu_id,
	input  array_class_t                  read_data_class,
	input  logic [`DATA_BITS-1:0]         read_data_payload,
	input  logic [`VERTEX_COUNT_BITS-1:0] vertex_count_cu [0:`NUM_CU-1],
	input  logic [`EDGE_COUNT_BITS-1:0]   edge_count_cu   [0:`NUM_CU-1],
	output logic [`NUM_CU-1:0]            enable_cu,
	output logic [`NUM_CU-1:0]            read_response_cu_valid,
	output logic [`TAG_BITS-1:0]          read_response_cu_tag [0:`NUM_CU-1],
	output logic [`NUM_CU-1:0]            write_response_cu_valid,
	output logic [`TAG_BITS-1:0]          write_response_cu_tag [0:`NUM_CU-1],
	output logic [`NUM_CU-1:0]            read_data_cu_valid,
	output logic [`DATA_BITS-1:0]         read_data_cu_payload [0:`NUM_CU-1],
	output logic [`VERTEX_COUNT_BITS-1:0] vertex_done_total,
	output logic [`EDGE_COUNT_BITS-1:0]   edge_done_total
);

	logic                  enabled;
	logic                  rsp_edge_valid;
	cu_id_t                rsp_edge_cu_id;
	logic [`TAG_BITS-1:0]  rsp_edge_tag;
	logic                  data_edge_valid;
	cu_id_t                data_edge_cu_id;
	logic [`DATA_BITS-1:0] data_edge_payload;

	cu_enable_config u_config (
		.clock(clock), .rstn(rstn), .enabled_in(enabled_in),
		.cu_configure(cu_configure), .enabled(enabled), .enable_cu(enable_cu)
	);

	////////////////////////////////////////////////////////////
	// Read responses, classify then route
	////////////////////////////////////////////////////////////

	cu_response_classify #(.PAYLOAD_BITS(`TAG_BITS)) u_rsp_classify (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.in_valid(read_response_valid), .in_cu_id(read_response_cu_id),
		.in_class(read_response_class), .in_payload(read_response_tag),
		.out_valid(rsp_edge_valid), .out_cu_id(rsp_edge_cu_id), .out_payload(rsp_edge_tag)
	);

	cu_response_route #(.PAYLOAD_BITS(`TAG_BITS)) u_rsp_route (
		.clock(clock), .rstn(rstn), .enabled(enabled), .enable_cu(enable_cu),
		.in_valid(rsp_edge_valid), .in_cu_id(rsp_edge_cu_id), .in_payload(rsp_edge_tag),
		.cu_valid(read_response_cu_valid), .cu_payload(read_response_cu_tag)
	);

	// Write responses skip classification
	cu_response_route #(.PAYLOAD_BITS(`TAG_BITS)) u_wr_route (
		.clock(clock), .rstn(rstn), .enabled(enabled), .enable_cu(enable_cu),
		.in_valid(write_response_valid), .in_cu_id(write_response_cu_id),
		.in_payload(write_response_tag),
		.cu_valid(write_response_cu_valid), .cu_payload(write_response_cu_tag)
	);

	////////////////////////////////////////////////////////////
	// Read data, classify then route
	////////////////////////////////////////////////////////////

	cu_response_classify #(.PAYLOAD_BITS(`DATA_BITS)) u_data_classify (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.in_valid(read_data_valid), .in_cu_id(read_data_cu_id),
		.in_class(read_data_class), .in_payload(read_data_payload),
		.out_valid(data_edge_valid), .out_cu_id(data_edge_cu_id),
		.out_payload(data_edge_payload)
	);

	cu_response_route #(.PAYLOAD_BITS(`DATA_BITS)) u_data_route (
		.clock(clock), .rstn(rstn), .enabled(enabled), .enable_cu(enable_cu),
		.in_valid(data_edge_valid), .in_cu_id(data_edge_cu_id),
		.in_payload(data_edge_payload),
		.cu_valid(read_data_cu_valid), .cu_payload(read_data_cu_payload)
	);

	cu_done_counter u_done (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.vertex_count_cu(vertex_count_cu), .edge_count_cu(edge_count_cu),
		.vertex_done_total(vertex_done_total), .edge_done_total(edge_done_total)
	);

endmodule

`default_nettype wire

// File: bench/cu_vertex_control_properties.sv
/*
 * Vertex CU control properties
 * Lane valids stay one-hot, follow the enable mask and stay quiet in reset
 */
`timescale 1ns/1ps
`default_nettype none
`include "cu_ctrl_defines.svh"

module cu_vertex_control_properties (
	input logic                          clock,
	input logic                          rstn,
	input logic [`NUM_CU-1:0]            enable_cu,
	input logic [`NUM_CU-1:0]            read_response_cu_valid,
	input logic [`NUM_CU-1:0]            write_response_cu_valid,
	input logic [`NUM_CU-1:0]            read_data_cu_valid,
	input logic [`VERTEX_COUNT_BITS-1:0] vertex_done_total,
	input logic [`EDGE_COUNT_BITS-1:0]   edge_done_total
);

	int failures = 0;

	// At most one CU lane per channel
	rsp_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(read_response_cu_valid))
		else begin
			failures++;
			$error("read response valids not one-hot");
		end
	wr_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(write_response_cu_valid))
		else begin
			failures++;
			$error("write response valids not one-hot");
		end
	data_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(read_data_cu_valid))
		else begin
			failures++;
			$error("read data valids not one-hot");
		end

	// Delivery only to enabled CUs
	rsp_enabled: assert property (@(posedge clock) disable iff (!rstn)
		(read_response_cu_valid & ~enable_cu) == '0)
		else begin
			failures++;
			$error("read response to disabled CU");
		end
	wr_enabled: assert property (@(posedge clock) disable iff (!rstn)
		(write_response_cu_valid & ~enable_cu) == '0)
		else begin
			failures++;
			$error("write response to disabled CU");
		end
	data_enabled: assert property (@(posedge clock) disable iff (!rstn)
		(read_data_cu_valid & ~enable_cu) == '0)
		else begin
			failures++;
			$error("read data to disabled CU");
		end

	reset_quiet: assert property (@(posedge clock) !rstn |->
		(read_response_cu_valid == '0 && write_response_cu_valid == '0
		&& read_data_cu_valid == '0 && enable_cu == '0
		&& vertex_done_total == '0 && edge_done_total == '0))
		else begin
			failures++;
			$error("outputs active while in reset");
		end

endmodule

bind cu_vertex_control_top cu_vertex_control_properties u_properties (.*);

`default_nettype wire

// File: bench/cu_vertex_control_tb.sv
/*
 * Vertex CU control testbench
 * Random response traffic checked against a cycle model of the
 * routing, configuration and done-total rules
 */
`timescale 1ns/1ps
`default_nettype none
`include "cu_ctrl_defines.svh"

module cu_vertex_control_tb
	import cu_ctrl_pkg::*;
();

	localparam int HALF_PERIOD     = 50;
	localparam int RESET_CYCLES    = 8;
	localparam int TRAFFIC_CYCLES  = 64;
	localparam int DISABLED_CYCLES = 16;
	localparam int DRAIN_CYCLES    = 7;
	localparam int CONFIG_CYCLES   = 5;
	localparam int TEST_CYCLES_MAX = TRAFFIC_CYCLES + DISABLED_CYCLES + 2 * DRAIN_CYCLES
		+ 4 * CONFIG_CYCLES;
	localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 6 * TEST_CYCLES_MAX + 20;

	logic                          clock = 1'b0;
	logic                          rstn;
	logic                          enabled_in;
	logic [`CONFIG_BITS-1:0]       cu_configure;
	logic                          read_response_valid;
	cu_id_t                        read_response_cu_id;
	array_class_t                  read_response_class;
	logic [`TAG_BITS-1:0]          read_response_tag;
	logic                          write_response_valid;
	cu_id_t                        write_response_cu_id;
	logic [`TAG_BITS-1:0]          write_response_tag;
	logic                          read_data_valid;
	cu_id_t                        read_data_cu_id;
	array_class_t                  read_data_class;
	logic [`DATA_BITS-1:0]         read_data_payload;
	logic [`VERTEX_COUNT_BITS-1:0] vertex_count_cu [0:`NUM_CU-1];
	logic [`EDGE_COUNT_BITS-1:0]   edge_count_cu   [0:`NUM_CU-1];
	logic [`NUM_CU-1:0]            enable_cu;
	logic [`NUM_CU-1:0]            read_response_cu_valid;
	logic [`TAG_BITS-1:0]          read_response_cu_tag [0:`NUM_CU-1];
	logic [`NUM_CU-1:0]            write_response_cu_valid;
	logic [`TAG_BITS-1:0]          write_response_cu_tag [0:`NUM_CU-1];
	logic [`NUM_CU-1:0]            read_data_cu_valid;
	logic [`DATA_BITS-1:0]         read_data_cu_payload [0:`NUM_CU-1];
	logic [`VERTEX_COUNT_BITS-1:0] vertex_done_total;
	logic [`EDGE_COUNT_BITS-1:0]   edge_done_total;

	integer seed = 32'hec9f;
	int     errors = 0;
	int     errors_at_start = 0;
	int     tests_passed = 0;
	int     tests_failed = 0;
	int     cycles = 0;

	// Model state with items packed as {valid, cu_id, payload}
	logic        m_enabled;
	logic [31:0] m_count;
	logic [3:0]  m_mask;
	logic [31:0] v_pending;
	logic [31:0] e_pending;
	logic [31:0] v_total;
	logic [31:0] e_total;
	logic [66:0] rsp_stage_q [$];
	logic [66:0] rsp_lane_q [$];
	logic [66:0] wr_lane_q [$];
	logic [66:0] data_stage_q [$];
	logic [66:0] data_lane_q [$];
	logic [66:0] rsp_exp;
	logic [66:0] wr_exp;
	logic [66:0] data_exp;

	cu_vertex_control_top UUT (.*);

	always #HALF_PERIOD clock = ~clock;

	function automatic logic edge_class(input array_class_t c);
		return c inside {EDGE_ARRAY_SRC, EDGE_ARRAY_DEST, EDGE_ARRAY_WEIGHT,
			INV_EDGE_ARRAY_SRC, INV_EDGE_ARRAY_DEST, INV_EDGE_ARRAY_WEIGHT};
	endfunction

	// Bit i is set while i is below the active count
	function automatic logic [3:0] mask_of(input logic [31:0] count);
		logic [3:0] mask;
		for (int i = 0; i < `NUM_CU; i++) begin
			mask[i] = count > i;
		end
		return mask;
	endfunction

	function automatic logic [66:0] deliver_item(input logic [66:0] item);
		return {item[66] && m_enabled && m_mask[item[65:64]], item[65:0]};
	endfunction

	function automatic logic [3:0] lane_valid(input logic [66:0] item);
		return item[66] ? (4'b1 << item[65:64]) : 4'b0;
	endfunction

	function automatic logic [63:0] lane_payload(input logic [66:0] item, input int lane);
		return (item[66] && item[65:64] == lane) ? item[63:0] : '0;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Cycle model, fed with the values present before each edge
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (!rstn) begin
			m_enabled = 1'b0;
			m_count   = '0;
			m_mask    = '0;
			v_total   = '0;
			e_total   = '0;
			rsp_exp   = '0;
			wr_exp    = '0;
			data_exp  = '0;
			rsp_stage_q.delete();
			rsp_lane_q.delete();
			wr_lane_q.delete();
			data_stage_q.delete();
			data_lane_q.delete();
		end else begin
			rsp_exp  = (rsp_lane_q.size() > 0) ? rsp_lane_q.pop_front() : '0;
			wr_exp   = (wr_lane_q.size() > 0) ? wr_lane_q.pop_front() : '0;
			data_exp = (data_lane_q.size() > 0) ? data_lane_q.pop_front() : '0;
			if (rsp_stage_q.size() > 0) begin
				rsp_lane_q.push_back(deliver_item(rsp_stage_q.pop_front()));
			end
			if (data_stage_q.size() > 0) begin
				data_lane_q.push_back(deliver_item(data_stage_q.pop_front()));
			end
			wr_lane_q.push_back(deliver_item({write_response_valid, write_response_cu_id,
				56'd0, write_response_tag}));
			rsp_stage_q.push_back({read_response_valid && m_enabled
				&& edge_class(read_response_class), read_response_cu_id, 56'd0, read_response_tag});
			data_stage_q.push_back({read_data_valid && m_enabled && edge_class(read_data_class),
				read_data_cu_id, read_data_payload});
			if (m_enabled) begin
				v_total = v_pending;
				e_total = e_pending;
				m_mask  = mask_of(m_count);
				if (cu_configure != '0) begin
					m_count = cu_configure[31:0];
				end
			end
			v_pending = '0;
			e_pending = '0;
			foreach (vertex_count_cu[i]) begin
				v_pending += vertex_count_cu[i];
				e_pending += edge_count_cu[i];
			end
			m_enabled = enabled_in;
		end
	end

	always @(negedge clock) begin
		if (rstn) begin
			check_value("enable_cu", m_mask, enable_cu);
			check_value("vertex_done_total", v_total, vertex_done_total);
			check_value("edge_done_total", e_total, edge_done_total);
			check_value("read_response_cu_valid", lane_valid(rsp_exp), read_response_cu_valid);
			check_value("write_response_cu_valid", lane_valid(wr_exp), write_response_cu_valid);
			check_value("read_data_cu_valid", lane_valid(data_exp), read_data_cu_valid);
			for (int i = 0; i < `NUM_CU; i++) begin
				check_value($sformatf("read_response_cu_tag[%0d]", i), lane_payload(rsp_exp, i),
					read_response_cu_tag[i]);
				check_value($sformatf("write_response_cu_tag[%0d]", i), lane_payload(wr_exp, i),
					write_response_cu_tag[i]);
				check_value($sformatf("read_data_cu_payload[%0d]", i), lane_payload(data_exp, i),
					read_data_cu_payload[i]);
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// One-cycle word, then wait until the mask has settled
	task automatic configure(input logic [63:0] word);
		@(posedge clock);
		cu_configure <= word;
		@(posedge clock);
		cu_configure <= '0;
		repeat (CONFIG_CYCLES - 2) @(posedge clock);
	endtask

	task automatic send_traffic(input int n, input logic rsp_on, input logic wr_on,
		input logic data_on);
		repeat (n) begin
			@(posedge clock);
			read_response_valid  <= rsp_on;
			read_response_cu_id  <= cu_id_t'($random(seed));
			read_response_class  <= array_class_t'(4'($random(seed)));
			read_response_tag    <= $random(seed);
			write_response_valid <= wr_on;
			write_response_cu_id <= cu_id_t'($random(seed));
			write_response_tag   <= $random(seed);
			read_data_valid      <= data_on;
			read_data_cu_id      <= cu_id_t'($random(seed));
			read_data_class      <= array_class_t'(4'($random(seed)));
			read_data_payload    <= {$random(seed), $random(seed)};
			foreach (vertex_count_cu[i]) begin
				vertex_count_cu[i] <= $random(seed);
				edge_count_cu[i]   <= $random(seed);
			end
		end
		@(posedge clock);
		read_response_valid  <= 1'b0;
		write_response_valid <= 1'b0;
		read_data_valid      <= 1'b0;
		repeat (DRAIN_CYCLES - 1) @(posedge clock);
	endtask

	task automatic finish_test(input string name);
		int failed_checks;
		failed_checks = errors + UUT.u_properties.failures;
		if (failed_checks == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d failed checks", name, failed_checks - errors_at_start);
		end
		errors_at_start = failed_checks;
	endtask

	initial begin
		rstn                 <= 1'b0;
		enabled_in           <= 1'b0;
		cu_configure         <= '0;
		read_response_valid  <= 1'b0;
		read_response_cu_id  <= '0;
		read_response_class  <= STRUCT_INVALID;
		read_response_tag    <= '0;
		write_response_valid <= 1'b0;
		write_response_cu_id <= '0;
		write_response_tag   <= '0;
		read_data_valid      <= 1'b0;
		read_data_cu_id      <= '0;
		read_data_class      <= STRUCT_INVALID;
		read_data_payload    <= '0;
		foreach (vertex_count_cu[i]) begin
			vertex_count_cu[i] <= '0;
			edge_count_cu[i]   <= '0;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		rstn <= 1'b1;
		repeat (3) @(posedge clock);
		finish_test("reset");

		enabled_in <= 1'b1;
		configure(64'd2);
		configure(64'd0);
		configure(64'd9);
		configure(64'd3);
		finish_test("configuration");

		// CU 3 stays disabled here
		send_traffic(TRAFFIC_CYCLES, 1'b1, 1'b0, 1'b0);
		enabled_in <= 1'b0;
		send_traffic(DISABLED_CYCLES, 1'b1, 1'b0, 1'b0);
		enabled_in <= 1'b1;
		finish_test("read responses");

		configure(64'd4);
		send_traffic(TRAFFIC_CYCLES, 1'b0, 1'b1, 1'b0);
		finish_test("write responses");

		configure(64'd2);
		send_traffic(TRAFFIC_CYCLES, 1'b0, 1'b0, 1'b1);
		finish_test("read data");

		send_traffic(TRAFFIC_CYCLES / 2, 1'b1, 1'b1, 1'b1);
		enabled_in <= 1'b0;
		send_traffic(DISABLED_CYCLES, 1'b0, 1'b0, 1'b0);
		enabled_in <= 1'b1;
		repeat (3) @(posedge clock);
		finish_test("done totals");

		$display("tests passed %0d, tests failed %0d, failed checks %0d",
			tests_passed, tests_failed, errors + UUT.u_properties.failures);
		if (tests_failed == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/cu_ctrl_pkg.sv
rtl/cu_enable_config.sv
rtl/cu_response_classify.sv
rtl/cu_response_route.sv
rtl/cu_done_counter.sv
rtl/cu_vertex_control_top.sv
bench/cu_vertex_control_properties.sv
bench/cu_vertex_control_tb.sv

// File: Bender.yml
package:
  name: cu_vertex_control

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cu_ctrl_pkg.sv
      - rtl/cu_enable_config.sv
      - rtl/cu_response_classify.sv
      - rtl/cu_response_route.sv
      - rtl/cu_done_counter.sv
      - rtl/cu_vertex_control_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/cu_vertex_control_properties.sv
      - bench/cu_vertex_control_tb.sv
